//--- build.f
hw/armDecodePkg.sv
hw/decodeIf.sv
hw/classifyStage.sv
hw/dataProcTable.sv
hw/addrMode2Table.sv
hw/entryStage.sv
hw/armDecoderTop.sv
test/armDecoder_assertions.sv
test/armDecoderTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= armDecoderTb
RTL_TOP ?= armDecoderTop
FILELIST ?= build.f
OBJDIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: all lint build sim clean

all: sim

# static checks of the design alone and with the testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# status comes from the search for the pass line
sim: build
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

//--- test/armDecoderTb.sv
`timescale 1ns/1ps

module armDecoderTb;

    localparam int FETCH = 1;
    localparam int BRANCH = 64;

    logic clk;
    logic reset;
    logic instrValid;
    logic [31:0] instruction;
    logic entryValid;
    logic [9:0] entryState;

    int seed = 8538;
    int errorCount = 0;
    // counts falling edges, used for latency
    int cycleCount = 0;
    // expected state per word in flight
    logic [9:0] expectQ[$];
    // falling-edge count at which each strobe was seen
    int strobeQ[$];

    // microcode map, indexed by {S, opcode}
    int dpTable [32] = '{500, 504, 489, 492, 7, 494, 496, 498,
                         487, 488, 485, 486, 506, 226, 502, 484,
                         499, 503, 490, 491, 5, 493, 495, 497,
                         487, 488, 485, 486, 505, 225, 501, 483};
    // indexed by P U B W L
    // user-mode codes (P low, W high) hold the fetch state
    int memImmTable [32] = '{106, 330, 1, 1, 49, 218, 1, 1,
                             101, 325, 1, 1, 44, 213, 1, 1,
                             69, 293, 86, 310, 12, 181, 29, 198,
                             65, 289, 81, 305, 8, 177, 24, 193};
    int memRegTable [32] = '{116, 340, 1, 1, 59, 228, 1, 1,
                             111, 335, 1, 1, 54, 223, 1, 1,
                             77, 301, 96, 320, 20, 189, 34, 208,
                             73, 297, 91, 315, 16, 185, 34, 203};

    armDecoderTop dut_i
    (
        .clk(clk),
        .reset(reset),
        .instrValid(instrValid),
        .instruction(instruction),
        .entryValid(entryValid),
        .entryState(entryState)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // expected entry state of one word
    function automatic logic [9:0] expectedEntry(logic [31:0] w);
        int state;
        case (w[27:25])
            3'b001: state = dpTable[{w[20], w[24:21]}];
            3'b010: state = memImmTable[w[24:20]];
            // shifted register offsets drop to fetch
            3'b011: state = (w[11:4] == 8'h00) ? memRegTable[w[24:20]] : FETCH;
            3'b101: state = BRANCH;
            default: state = FETCH;
        endcase
        return 10'(state);
    endfunction

    task automatic checkEqual(string what, logic [9:0] actual, logic [9:0] expected);
        if (actual !== expected)
        begin
            errorCount++;
            $display("Mismatch at time %0t: %s is %0d, expected %0d", $time, what, actual,
                     expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic sendWord(logic [31:0] w);
        @(posedge clk);
        instrValid <= 1'b1;
        instruction <= w;
        expectQ.push_back(expectedEntry(w));
    endtask

    task automatic idleCycles(int n);
        repeat (n)
        begin
            @(posedge clk);
            instrValid <= 1'b0;
            // junk on the bus while idle
            instruction <= $random(seed);
        end
    endtask

    task automatic waitDrained(int limit);
        int waited;
        waited = 0;
        while (expectQ.size() != 0 && waited < limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (expectQ.size() != 0)
        begin
            $display("Timeout at time %0t: %0d results never came out", $time, expectQ.size());
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout waiting for results");
        end
    endtask

    // all opcodes, S clear then S set, random other fields
    task automatic dataProcSweep();
        logic [31:0] w;
        for (int s = 0; s < 2; s++)
        begin
            for (int op = 0; op < 16; op++)
            begin
                w = $random(seed);
                w[27:25] = 3'b001;
                w[24:21] = 4'(op);
                w[20] = 1'(s);
                sendWord(w);
            end
        end
    endtask

    // form 0 immediate, form 1 plain register, form 2 shifted register
    task automatic addrMode2Sweep();
        logic [31:0] w;
        for (int form = 0; form < 3; form++)
        begin
            for (int code = 0; code < 32; code++)
            begin
                w = $random(seed);
                w[24:20] = 5'(code);
                if (form == 0)
                begin
                    w[27:25] = 3'b010;
                end
                else
                begin
                    w[27:25] = 3'b011;
                    w[11:4] = (form == 1) ? 8'h00 : (w[11:4] | 8'h10);
                end
                sendWord(w);
            end
        end
    endtask

    task automatic branchAndOtherWords();
        logic [31:0] w;
        for (int i = 0; i < 48; i++)
        begin
            w = $random(seed);
            case (i % 6)
                0, 1: w[27:25] = 3'b101;
                2:
                begin
                    // halfword transfer shape
                    w[27:25] = 3'b000;
                    w[7] = 1'b1;
                    w[4] = 1'b1;
                end
                // ldm/stm
                3: w[27:25] = 3'b100;
                4: w[27:25] = 3'b110;
                default: w[27:25] = 3'b111;
            endcase
            sendWord(w);
        end
    endtask

    task automatic randomMix(int count);
        logic [31:0] w;
        int pick;
        int gap;
        for (int i = 0; i < count; i++)
        begin
            w = $random(seed);
            pick = $unsigned($random(seed)) % 6;
            case (pick)
                0: w[27:25] = 3'b001;
                1: w[27:25] = 3'b010;
                2:
                begin
                    w[27:25] = 3'b011;
                    // about half get a plain register offset
                    if (w[31])
                    begin
                        w[11:4] = 8'h00;
                    end
                end
                3: w[27:25] = 3'b101;
                default:
                begin
                    // raw random word
                end
            endcase
            sendWord(w);
            // half back to back, half with one or two idle cycles
            gap = $unsigned($random(seed)) % 4;
            if (gap > 1)
            begin
                idleCycles(gap - 1);
            end
        end
    endtask

    // compare on the falling edge, outputs settled
    initial
    begin : compareResults
        logic [9:0] expected;
        int sentAt;
        forever
        begin
            @(negedge clk);
            cycleCount++;
            if (reset === 1'b1)
            begin
                checkEqual("entryValid during reset", 10'(entryValid), 10'd0);
            end
            else if (entryValid === 1'b1)
            begin
                if (expectQ.size() == 0 || strobeQ.size() == 0)
                begin
                    $display("Error at time %0t: a result came out with no word outstanding",
                             $time);
                    $display("TESTBENCH FAILED");
                    $fatal(1, "unrequested output");
                end
                else
                begin
                    expected = expectQ.pop_front();
                    sentAt = strobeQ.pop_front();
                    checkEqual("entryState", entryState, expected);
                    checkEqual("latency in cycles", 10'(cycleCount - sentAt), 10'd2);
                end
            end
            if (instrValid === 1'b1)
            begin
                strobeQ.push_back(cycleCount);
            end
        end
    end

    initial
    begin
        reset = 1'b1;
        instrValid = 1'b0;
        instruction = '0;
        repeat (16)
        begin
            @(posedge clk);
        end
        reset <= 1'b0;
        // quiet bus, nothing may come out
        idleCycles(8);
        dataProcSweep();
        addrMode2Sweep();
        branchAndOtherWords();
        idleCycles(3);
        randomMix(300);
        idleCycles(1);
        waitDrained(20);
        if (errorCount == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- test/armDecoder_assertions.sv
`timescale 1ns/1ps

// port-level checks on the decoder
module armDecoderAssertions
(
    input logic clk,
    input logic reset,
    input logic instrValid,
    input logic entryValid,
    input armDecodePkg::entryState_t entryState
);

    // output strobe cleared by a reset cycle
    resetClearsValid: assert property (@(posedge clk) reset |=> !entryValid)
        else $error("entryValid high after a reset cycle");

    // two stages, one result per strobe
    twoCycleLatency: assert property (@(posedge clk) disable iff (reset)
        entryValid == $past(instrValid, 2))
        else $error("entryValid does not follow instrValid by two cycles");

    // no map entry is zero
    nonZeroEntry: assert property (@(posedge clk) disable iff (reset)
        entryValid |-> entryState != 10'd0)
        else $error("entryState is zero on a valid result");

endmodule

bind armDecoderTop armDecoderAssertions portChecks_i
(
    .clk(clk),
    .reset(reset),
    .instrValid(instrValid),
    .entryValid(entryValid),
    .entryState(entryState)
);

//--- hw/armDecoderTop.sv
`timescale 1ns/1ps

// two-stage decoder, word in, microcode entry state out two cycles later
module armDecoderTop
(
    input logic clk,
    input logic reset,
    // one strobe per word
    input logic instrValid,
    input armDecodePkg::instrWord_t instruction,
    // must be taken the cycle it is high
    output logic entryValid,
    output armDecodePkg::entryState_t entryState
);

    // classified word between the stages
    decodeIf decoded();

    // stage 1, class and fields
    classifyStage classifyStage_i
    (
        .clk(clk),
        .reset(reset),
        .instrValid(instrValid),
        .instruction(instruction),
        .decoded(decoded.stage)
    );

    // stage 2, table lookup
    entryStage entryStage_i
    (
        .clk(clk),
        .reset(reset),
        .decoded(decoded.lookup),
        .entryValid(entryValid),
        .entryState(entryState)
    );

endmodule

//--- hw/entryStage.sv
`timescale 1ns/1ps

module entryStage
(
    input logic clk,
    input logic reset,
    decodeIf.lookup decoded,
    output logic entryValid,
    output armDecodePkg::entryState_t entryState
);

    // table outputs
    armDecodePkg::entryState_t dpState;
    armDecodePkg::entryState_t memState;
    // chosen entry, before the register
    armDecodePkg::entryState_t nextState;
    // mode 2 table flavour comes straight from the class
    logic registerOffset;

    assign registerOffset = (decoded.iclass == armDecodePkg::CLASS_MEM_REG);

    dataProcTable dataProcTable_i
    (
        .opcode(decoded.opcode),
        .setFlags(decoded.setFlags),
        .state(dpState)
    );

    addrMode2Table addrMode2Table_i
    (
        .memMode(decoded.memMode),
        .registerOffset(registerOffset),
        .state(memState)
    );

    // pick by class
    always_comb
    begin
        case (decoded.iclass)
            armDecodePkg::CLASS_DATA_IMM: nextState = dpState;
            armDecodePkg::CLASS_MEM_IMM: nextState = memState;
            armDecodePkg::CLASS_MEM_REG: nextState = memState;
            armDecodePkg::CLASS_BRANCH: nextState = armDecodePkg::BRANCH_STATE;
            default: nextState = armDecodePkg::FETCH_STATE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            entryValid <= 1'b0;
        end
        else
        begin
            entryValid <= decoded.valid;
        end
    end

    // result holds while nothing new arrives
    always_ff @(posedge clk)
    begin
        if (decoded.valid)
        begin
            entryState <= nextState;
        end
    end

endmodule

//--- hw/addrMode2Table.sv
`timescale 1ns/1ps

module addrMode2Table
(
    input armDecodePkg::memMode_t memMode,
    input logic registerOffset,
    output armDecodePkg::entryState_t state
);

    // keyed on P U B W L
    // P=0 with W=1 is the user-mode (T) form, not handled here
    always_comb
    begin
        if (!registerOffset)
        begin
            case (memMode)
                // strb immediate
                5'b11100: state = 10'd8;
                5'b10100: state = 10'd12;
                5'b11110: state = 10'd24;
                5'b10110: state = 10'd29;
                5'b01100: state = 10'd44;
                5'b00100: state = 10'd49;
                // str immediate
                5'b11000: state = 10'd65;
                5'b10000: state = 10'd69;
                5'b11010: state = 10'd81;
                5'b10010: state = 10'd86;
                5'b01000: state = 10'd101;
                5'b00000: state = 10'd106;
                // ldrb immediate
                5'b11101: state = 10'd177;
                5'b10101: state = 10'd181;
                5'b11111: state = 10'd193;
                5'b10111: state = 10'd198;
                5'b01101: state = 10'd213;
                5'b00101: state = 10'd218;
                // ldr immediate
                5'b11001: state = 10'd289;
                5'b10001: state = 10'd293;
                5'b11011: state = 10'd305;
                5'b10011: state = 10'd310;
                5'b01001: state = 10'd325;
                5'b00001: state = 10'd330;
                // user-mode transfers fall back to fetch
                default: state = armDecodePkg::FETCH_STATE;
            endcase
        end
        else
        begin
            case (memMode)
                // strb register
                5'b11100: state = 10'd16;
                5'b10100: state = 10'd20;
                // pre-index add and sub share one entry in the rom
                5'b11110: state = 10'd34;
                5'b10110: state = 10'd34;
                5'b01100: state = 10'd54;
                5'b00100: state = 10'd59;
                // str register
                5'b11000: state = 10'd73;
                5'b10000: state = 10'd77;
                5'b11010: state = 10'd91;
                5'b10010: state = 10'd96;
                5'b01000: state = 10'd111;
                5'b00000: state = 10'd116;
                // ldrb register
                5'b11101: state = 10'd185;
                5'b10101: state = 10'd189;
                5'b11111: state = 10'd203;
                5'b10111: state = 10'd208;
                5'b01101: state = 10'd223;
                5'b00101: state = 10'd228;
                // ldr register
                5'b11001: state = 10'd297;
                5'b10001: state = 10'd301;
                5'b11011: state = 10'd315;
                5'b10011: state = 10'd320;
                5'b01001: state = 10'd335;
                // out of sequence with its neighbours, kept as in the rom
                5'b00001: state = 10'd340;
                default: state = armDecodePkg::FETCH_STATE;
            endcase
        end
    end

endmodule

//--- hw/dataProcTable.sv
`timescale 1ns/1ps

module dataProcTable
(
    input armDecodePkg::dpOpcode_t opcode,
    input logic setFlags,
    output armDecodePkg::entryState_t state
);

    // 32-entry map, opcode with and without S
    // compares and tests land on one state either way
    always_comb
    begin
        if (!setFlags)
        begin
            case (opcode)
                // and, eor
                4'b0000: state = 10'd500;
                4'b0001: state = 10'd504;
                // sub, rsb
                4'b0010: state = 10'd489;
                4'b0011: state = 10'd492;
                // add sits low in the rom
                4'b0100: state = 10'd7;
                // adc, sbc, rsc
                4'b0101: state = 10'd494;
                4'b0110: state = 10'd496;
                4'b0111: state = 10'd498;
                // tst, teq, cmp, cmn
                4'b1000: state = 10'd487;
                4'b1001: state = 10'd488;
                4'b1010: state = 10'd485;
                4'b1011: state = 10'd486;
                // orr, mov, bic, mvn
                4'b1100: state = 10'd506;
                4'b1101: state = 10'd226;
                4'b1110: state = 10'd502;
                default: state = 10'd484;
            endcase
        end
        else
        begin
            case (opcode)
                // ands, eors
                4'b0000: state = 10'd499;
                4'b0001: state = 10'd503;
                // subs, rsbs
                4'b0010: state = 10'd490;
                4'b0011: state = 10'd491;
                // adds
                4'b0100: state = 10'd5;
                // adcs, sbcs, rscs
                4'b0101: state = 10'd493;
                4'b0110: state = 10'd495;
                4'b0111: state = 10'd497;
                // S is implied for these four
                4'b1000: state = 10'd487;
                4'b1001: state = 10'd488;
                4'b1010: state = 10'd485;
                4'b1011: state = 10'd486;
                // orrs, movs, bics, mvns
                4'b1100: state = 10'd505;
                4'b1101: state = 10'd225;
                4'b1110: state = 10'd501;
                default: state = 10'd483;
            endcase
        end
    end

endmodule

//--- hw/classifyStage.sv
`timescale 1ns/1ps

module classifyStage
(
    input logic clk,
    input logic reset,
    input logic instrValid,
    input armDecodePkg::instrWord_t instruction,
    decodeIf.stage decoded
);

    // class of the incoming word, before the register
    armDecodePkg::instrClass_t nextClass;

    // register form of mode 2 is only taken with no shift at all
    logic zeroShift;

    assign zeroShift = (instruction[11:4] == 8'h00);

    // bits 27:25 pick the class
    always_comb
    begin
        case (instruction[27:25])
            3'b001:
            begin
                nextClass = armDecodePkg::CLASS_DATA_IMM;
            end
            3'b010:
            begin
                nextClass = armDecodePkg::CLASS_MEM_IMM;
            end
            3'b011:
            begin
                // shifted register offsets are not in the map
                if (zeroShift)
                begin
                    nextClass = armDecodePkg::CLASS_MEM_REG;
                end
                else
                begin
                    nextClass = armDecodePkg::CLASS_OTHER;
                end
            end
            3'b101:
            begin
                nextClass = armDecodePkg::CLASS_BRANCH;
            end
            default:
            begin
                // mode 3, ldm/stm, coprocessor, swi and the rest
                nextClass = armDecodePkg::CLASS_OTHER;
            end
        endcase
    end

    // valid strobe, one cycle later
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            decoded.valid <= 1'b0;
        end
        else
        begin
            decoded.valid <= instrValid;
        end
    end

    // fields only move with a new word
    always_ff @(posedge clk)
    begin
        if (instrValid)
        begin
            decoded.iclass <= nextClass;
            decoded.opcode <= instruction[24:21];
            decoded.setFlags <= instruction[20];
            // P U B W L
            decoded.memMode <= instruction[24:20];
        end
    end

endmodule

//--- hw/decodeIf.sv
`timescale 1ns/1ps

// one classified instruction between the two pipeline stages
interface decodeIf;

    // one-cycle strobe, no back-pressure
    logic valid;
    armDecodePkg::instrClass_t iclass;
    armDecodePkg::dpOpcode_t opcode;
    // S bit, bit 20
    logic setFlags;
    // P/U/B/W/L
    armDecodePkg::memMode_t memMode;

    // classify side drives everything
    modport stage (output valid, output iclass, output opcode, output setFlags,
                   output memMode);

    // entry side only looks
    modport lookup (input valid, input iclass, input opcode, input setFlags,
                    input memMode);

endinterface

//--- hw/armDecodePkg.sv
package armDecodePkg;

    // raw 32-bit instruction word as fetched
    typedef logic [31:0] instrWord_t;

    // microcode entry state number that the control unit jumps to
    typedef logic [9:0] entryState_t;

    // data-processing opcode field, bits 24:21
    typedef logic [3:0] dpOpcode_t;

    // addressing mode 2 control bits 24:20
    // order is P, U, B, W, L from msb to lsb
    typedef logic [4:0] memMode_t;

    // coarse instruction class, decided in the first stage
    typedef enum logic [2:0]
    {
        // data processing, 32-bit rotated immediate
        CLASS_DATA_IMM,
        // single word/byte transfer, 12-bit immediate offset
        CLASS_MEM_IMM,
        // single word/byte transfer, plain register offset
        CLASS_MEM_REG,
        // B and BL
        CLASS_BRANCH,
        // everything else, including mode 3 and ldm/stm
        CLASS_OTHER
    } instrClass_t;

    // fetch state, also the target for anything not decoded
    localparam entryState_t FETCH_STATE = 10'd1;

    // common branch entry
    localparam entryState_t BRANCH_STATE = 10'd64;

endpackage
